/* source/mem_fifo_pkg.sv */
//----------------------------------------
// Memory FIFO shared types and constants
// Word type, register map, readback and BIST codes
//----------------------------------------
`default_nettype none

package mem_fifo_pkg;

  // Payload word carried on every stream
  typedef logic [63:0] word_t;

  // Offsets from the FIFO settings base
  localparam int SR_FIFO_SEL = 0;
  localparam int SR_FIFO_CLR = 1;

  // Offsets from the BIST settings base
  localparam int SR_BIST_CTRL = 0;
  localparam int SR_BIST_CFG  = 1;
  localparam int SR_BIST_SEED = 2;

  typedef enum logic [1:0] {
    RB_FIFO_STATUS,
    RB_BIST_STATUS,
    RB_XFER_COUNT,
    RB_CYCLE_COUNT
  } rb_sel_e;

  typedef enum logic [1:0] {
    BIST_OK       = 2'b00,
    BIST_DATA_ERR = 2'b01,
    BIST_LEN_ERR  = 2'b10
  } bist_err_e;

endpackage

`default_nettype wire

/* source/stream_router.sv */
//----------------------------------------
// Stream router
// User/BIST mux in front of the FIFO and demux behind it
//----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module stream_router (
  input  logic                 bus_clk,
  input  logic                 rst,
  input  logic                 bist_mode,
  input  mem_fifo_pkg::word_t  usr_tdata,
  input  logic                 usr_tlast,
  input  logic                 usr_tvalid,
  output logic                 usr_tready,
  input  mem_fifo_pkg::word_t  gen_tdata,
  input  logic                 gen_tlast,
  input  logic                 gen_tvalid,
  output logic                 gen_tready,
  output mem_fifo_pkg::word_t  fifo_in_tdata,
  output logic                 fifo_in_tlast,
  output logic                 fifo_in_tvalid,
  input  logic                 fifo_in_tready,
  input  mem_fifo_pkg::word_t  fifo_out_tdata,
  input  logic                 fifo_out_tlast,
  input  logic                 fifo_out_tvalid,
  output logic                 fifo_out_tready,
  output mem_fifo_pkg::word_t  o_tdata,
  output logic                 o_tlast,
  output logic                 o_tvalid,
  input  logic                 o_tready,
  output mem_fifo_pkg::word_t  chk_tdata,
  output logic                 chk_tlast,
  output logic                 chk_tvalid,
  input  mem_fifo_pkg::word_t  forced_bit_err
);

  logic in_sel;
  logic in_open;
  logic out_sel;
  logic out_open;
  logic in_beat;
  logic out_beat;

  // Input side mux
  assign fifo_in_tdata  = in_sel ? gen_tdata : usr_tdata;
  assign fifo_in_tlast  = in_sel ? gen_tlast : usr_tlast;
  assign fifo_in_tvalid = in_sel ? gen_tvalid : usr_tvalid;
  assign usr_tready     = ~in_sel & fifo_in_tready;
  assign gen_tready     = in_sel & fifo_in_tready;
  assign in_beat        = fifo_in_tvalid & fifo_in_tready;

  // Output side demux toward a checker that never stalls
  assign o_tdata         = fifo_out_tdata ^ forced_bit_err;
  assign chk_tdata       = fifo_out_tdata ^ forced_bit_err;
  assign o_tlast         = fifo_out_tlast;
  assign chk_tlast       = fifo_out_tlast;
  assign o_tvalid        = fifo_out_tvalid & ~out_sel;
  assign chk_tvalid      = fifo_out_tvalid & out_sel;
  assign fifo_out_tready = out_sel | o_tready;
  assign out_beat        = fifo_out_tvalid & fifo_out_tready;

  // Mode is sampled only between packets
  always_ff @(posedge bus_clk)
  begin
    if (rst)
    begin
      in_sel   <= 1'b0;
      in_open  <= 1'b0;
      out_sel  <= 1'b0;
      out_open <= 1'b0;
    end
    else
    begin
      if (in_beat)
        in_open <= ~fifo_in_tlast;
      if (in_beat ? fifo_in_tlast : ~in_open)
        in_sel <= bist_mode;
      if (out_beat)
        out_open <= ~fifo_out_tlast;
      if (out_beat ? fifo_out_tlast : ~out_open)
        out_sel <= bist_mode;
    end
  end

  assert property (@(posedge bus_clk) disable iff (rst)
    (in_open && !(in_beat && fifo_in_tlast)) |=> $stable(in_sel));

endmodule

`default_nettype wire

/* source/fifo_write_engine.sv */
//----------------------------------------
// FIFO write engine
// Skid buffer and write pointer for the shared memory
//----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fifo_write_engine #(
  parameter int ADDR_W = 8
) (
  input  logic                 bus_clk,
  input  logic                 rst,
  input  logic                 clr,
  input  mem_fifo_pkg::word_t  in_tdata,
  input  logic                 in_tlast,
  input  logic                 in_tvalid,
  output logic                 in_tready,
  input  logic [ADDR_W:0]      rd_ptr,
  output logic [ADDR_W:0]      wr_ptr,
  output logic                 wr_req,
  input  logic                 wr_gnt,
  output logic [ADDR_W-1:0]    wr_addr,
  output logic [64:0]          wr_data
);

  // Entries hold {last, data}
  logic [64:0] skid_q [2];
  logic        head_q;
  logic        tail_q;
  logic [1:0]  cnt_q;
  logic        full;
  logic        push;
  logic        pop;

  assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign in_tready = (cnt_q != 2'd2) && !full;
  assign wr_req    = (cnt_q != 2'd0) && !full;
  assign push      = in_tvalid & in_tready;
  assign pop       = wr_req & wr_gnt;
  assign wr_addr   = wr_ptr[ADDR_W-1:0];
  assign wr_data   = skid_q[head_q];

  always_ff @(posedge bus_clk)
  begin
    if (push)
      skid_q[tail_q] <= {in_tlast, in_tdata};
  end

  always_ff @(posedge bus_clk)
  begin
    if (rst || clr)
    begin
      head_q <= 1'b0;
      tail_q <= 1'b0;
      cnt_q  <= 2'd0;
      wr_ptr <= '0;
    end
    else
    begin
      if (push)
        tail_q <= ~tail_q;
      if (pop)
      begin
        head_q <= ~head_q;
        wr_ptr <= wr_ptr + 1'b1;
      end
      cnt_q <= cnt_q + 2'(push) - 2'(pop);
    end
  end

  // Arbiter must not grant into a full memory
  assert property (@(posedge bus_clk) disable iff (rst) wr_gnt |-> !full);

endmodule

`default_nettype wire

/* source/fifo_read_engine.sv */
//----------------------------------------
// FIFO read engine
// Prefetches memory words into a 2-entry output buffer
//----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fifo_read_engine #(
  parameter int ADDR_W = 8
) (
  input  logic                 bus_clk,
  input  logic                 rst,
  input  logic                 clr,
  input  logic [ADDR_W:0]      wr_ptr,
  output logic [ADDR_W:0]      rd_ptr,
  output logic                 rd_req,
  input  logic                 rd_gnt,
  output logic [ADDR_W-1:0]    rd_addr,
  input  logic [64:0]          rd_data,
  output mem_fifo_pkg::word_t  out_tdata,
  output logic                 out_tlast,
  output logic                 out_tvalid,
  input  logic                 out_tready,
  output logic [ADDR_W:0]      occupancy
);

  logic [64:0] pf_q [2];
  logic        head_q;
  logic        tail_q;
  logic [1:0]  cnt_q;
  logic        pend_q;
  logic        empty;
  logic        pop;
  logic [1:0]  slots;

  assign empty     = (rd_ptr == wr_ptr);
  assign occupancy = wr_ptr - rd_ptr;
  assign rd_addr   = rd_ptr[ADDR_W-1:0];

  assign out_tvalid = (cnt_q != 2'd0);
  assign {out_tlast, out_tdata} = pf_q[head_q];
  assign pop = out_tvalid & out_tready;

  // Buffered words plus the read still in flight
  assign slots  = cnt_q + 2'(pend_q);
  assign rd_req = !empty && ((slots < 2'd2) || pop);

  // Read data shows up one cycle after its grant
  always_ff @(posedge bus_clk)
  begin
    if (pend_q)
      pf_q[tail_q] <= rd_data;
  end

  always_ff @(posedge bus_clk)
  begin
    if (rst || clr)
    begin
      head_q <= 1'b0;
      tail_q <= 1'b0;
      cnt_q  <= 2'd0;
      pend_q <= 1'b0;
      rd_ptr <= '0;
    end
    else
    begin
      pend_q <= rd_req & rd_gnt;
      if (rd_req && rd_gnt)
        rd_ptr <= rd_ptr + 1'b1;
      if (pend_q)
        tail_q <= ~tail_q;
      if (pop)
        head_q <= ~head_q;
      cnt_q <= cnt_q + 2'(pend_q) - 2'(pop);
    end
  end

  // A returning word always finds a free entry
  assert property (@(posedge bus_clk) disable iff (rst || clr)
    pend_q |-> (cnt_q != 2'd2) || pop);

endmodule

`default_nettype wire

/* source/mem_port_arbiter.sv */
//----------------------------------------
// Memory port arbiter
// Round-robin access to a single-port word array
//----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_port_arbiter #(
  parameter int ADDR_W = 8
) (
  input  logic              bus_clk,
  input  logic              rst,
  input  logic              wr_req,
  output logic              wr_gnt,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [64:0]       wr_data,
  input  logic              rd_req,
  output logic              rd_gnt,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [64:0]       rd_data
);

  // Each entry is {last, data}
  logic [64:0] mem [2**ADDR_W];
  logic        last_wr_q;

  // On contention the side not served last time wins
  assign wr_gnt = wr_req & (~rd_req | ~last_wr_q);
  assign rd_gnt = rd_req & (~wr_req | last_wr_q);

  always_ff @(posedge bus_clk)
  begin
    if (wr_gnt)
      mem[wr_addr] <= wr_data;
    if (rd_gnt)
      rd_data <= mem[rd_addr];
  end

  always_ff @(posedge bus_clk)
  begin
    if (rst)
      last_wr_q <= 1'b0;
    else if (wr_gnt)
      last_wr_q <= 1'b1;
    else if (rd_gnt)
      last_wr_q <= 1'b0;
  end

  // One access per cycle
  assert property (@(posedge bus_clk) disable iff (rst) !(wr_gnt && rd_gnt));

endmodule

`default_nettype wire

/* source/bist_engine.sv */
//----------------------------------------
// BIST packet generator and checker
// Constant or ramp patterns with first-error capture
//----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module bist_engine (
  input  logic                     bus_clk,
  input  logic                     rst,
  input  logic                     go,
  input  logic                     cont,
  input  logic                     ramp,
  input  logic [12:0]              pkt_len,
  input  logic [17:0]              pkt_count,
  input  logic [31:0]              seed,
  output mem_fifo_pkg::word_t      gen_tdata,
  output logic                     gen_tlast,
  output logic                     gen_tvalid,
  input  logic                     gen_tready,
  input  mem_fifo_pkg::word_t      chk_tdata,
  input  logic                     chk_tlast,
  input  logic                     chk_tvalid,
  output logic                     running,
  output logic                     done,
  output mem_fifo_pkg::bist_err_e  error
);

  import mem_fifo_pkg::*;

  logic        go_q;
  logic        start;
  logic        gen_active;
  logic [12:0] gen_idx;
  logic [17:0] gen_pkt;
  logic [12:0] chk_idx;
  logic [17:0] pkts_out;
  logic        gen_end;
  logic        chk_end;
  logic        data_bad;
  logic        len_bad;

  // Pattern word for a given index inside the packet
  function automatic word_t pattern(input logic [12:0] idx);
    logic [31:0] half;
    half = ramp ? seed + {19'd0, idx} : seed;
    return {half, half};
  endfunction

  assign start      = go & ~go_q;
  assign gen_tvalid = gen_active;
  assign gen_tdata  = pattern(gen_idx);
  assign gen_tlast  = (gen_idx == pkt_len - 13'd1);
  assign gen_end    = gen_tvalid & gen_tready & gen_tlast;
  assign chk_end    = chk_tvalid & chk_tlast;

  assign data_bad = chk_tvalid && (chk_tdata != pattern(chk_idx));
  assign len_bad  = chk_tvalid && (chk_tlast != (chk_idx == pkt_len - 13'd1));

  always_ff @(posedge bus_clk)
  begin
    if (rst)
    begin
      go_q       <= 1'b0;
      gen_active <= 1'b0;
      gen_idx    <= '0;
      gen_pkt    <= '0;
      chk_idx    <= '0;
      pkts_out   <= '0;
      running    <= 1'b0;
      done       <= 1'b0;
      error      <= BIST_OK;
    end
    else if (start)
    begin
      go_q       <= 1'b1;
      gen_active <= 1'b1;
      gen_idx    <= '0;
      gen_pkt    <= '0;
      chk_idx    <= '0;
      pkts_out   <= '0;
      running    <= 1'b1;
      done       <= 1'b0;
      error      <= BIST_OK;
    end
    else
    begin
      go_q <= go;

      // Generator stops at a packet boundary
      if (gen_tvalid && gen_tready)
        gen_idx <= gen_tlast ? 13'd0 : gen_idx + 13'd1;
      if (gen_end)
      begin
        gen_pkt <= gen_pkt + 18'd1;
        if (!go || (!cont && gen_pkt == pkt_count - 18'd1))
          gen_active <= 1'b0;
      end

      // Checker
      if (chk_tvalid)
        chk_idx <= chk_tlast ? 13'd0 : chk_idx + 13'd1;
      if (error == BIST_OK && data_bad)
        error <= BIST_DATA_ERR;
      else if (error == BIST_OK && len_bad)
        error <= BIST_LEN_ERR;

      pkts_out <= pkts_out + 18'(gen_end) - 18'(chk_end);
      if (running && !gen_active && chk_end && pkts_out == 18'd1)
      begin
        running <= 1'b0;
        done    <= 1'b1;
      end
    end
  end

  // Completion only once every generated packet came back
  assert property (@(posedge bus_clk) disable iff (rst)
    $rose(done) |-> !gen_active && pkts_out == '0);

endmodule

`default_nettype wire

/* source/ctrl_regs.sv */
//----------------------------------------
// Settings registers and readback
// Also counts delivered words and busy cycles
//----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ctrl_regs #(
  parameter int ADDR_W       = 8,
  parameter int SR_FIFO_BASE = 0,
  parameter int SR_BIST_BASE = 4
) (
  input  logic                     bus_clk,
  input  logic                     rst,
  input  logic                     set_stb,
  input  logic [7:0]               set_addr,
  input  logic [31:0]              set_data,
  output logic [31:0]              rb_data,
  output logic                     bist_mode,
  output logic                     bist_go,
  output logic                     bist_cont,
  output logic                     bist_ramp,
  output logic [12:0]              pkt_len,
  output logic [17:0]              pkt_count,
  output logic [31:0]              seed,
  output logic                     fifo_clr,
  input  logic                     running,
  input  logic                     done,
  input  mem_fifo_pkg::bist_err_e  error,
  input  logic [ADDR_W:0]          occupancy,
  input  logic                     xfer_beat,
  input  logic                     fifo_busy
);

  import mem_fifo_pkg::*;

  rb_sel_e     rb_sel;
  logic [31:0] bist_cfg;
  logic [31:0] xfer_count;
  logic [31:0] cycle_count;

  assign bist_mode = bist_go | running;
  assign pkt_count = bist_cfg[17:0];
  assign pkt_len   = bist_cfg[30:18];
  assign bist_ramp = bist_cfg[31];

  always_ff @(posedge bus_clk)
  begin
    if (rst)
    begin
      rb_sel    <= RB_FIFO_STATUS;
      fifo_clr  <= 1'b0;
      bist_go   <= 1'b0;
      bist_cont <= 1'b0;
      bist_cfg  <= '0;
      seed      <= '0;
    end
    else if (set_stb)
    begin
      case (set_addr)
        8'(SR_FIFO_BASE + SR_FIFO_SEL):  rb_sel <= rb_sel_e'(set_data[1:0]);
        8'(SR_FIFO_BASE + SR_FIFO_CLR):  fifo_clr <= set_data[0];
        8'(SR_BIST_BASE + SR_BIST_CTRL): {bist_cont, bist_go} <= set_data[1:0];
        8'(SR_BIST_BASE + SR_BIST_CFG):  bist_cfg <= set_data;
        8'(SR_BIST_BASE + SR_BIST_SEED): seed <= set_data;
        default: ;
      endcase
    end
  end

  // Throughput counters
  always_ff @(posedge bus_clk)
  begin
    if (rst || fifo_clr)
    begin
      xfer_count  <= '0;
      cycle_count <= '0;
    end
    else
    begin
      xfer_count  <= xfer_count + 32'(xfer_beat);
      cycle_count <= cycle_count + 32'(fifo_busy);
    end
  end

  always_comb
  begin
    case (rb_sel)
      RB_FIFO_STATUS: rb_data = 32'(occupancy);
      RB_BIST_STATUS: rb_data = {28'd0, error, done, running};
      RB_XFER_COUNT:  rb_data = xfer_count;
      default:        rb_data = cycle_count;
    endcase
  end

endmodule

`default_nettype wire

/* source/mem_fifo_top.sv */
//----------------------------------------
// Memory FIFO top level with inline BIST
//----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_fifo_top #(
  parameter int ADDR_W       = 8,
  parameter int SR_FIFO_BASE = 0,
  parameter int SR_BIST_BASE = 4
) (
  input  logic                 bus_clk,
  input  logic                 rst,
  input  mem_fifo_pkg::word_t  i_tdata,
  input  logic                 i_tlast,
  input  logic                 i_tvalid,
  output logic                 i_tready,
  output mem_fifo_pkg::word_t  o_tdata,
  output logic                 o_tlast,
  output logic                 o_tvalid,
  input  logic                 o_tready,
  input  logic                 set_stb,
  input  logic [7:0]           set_addr,
  input  logic [31:0]          set_data,
  output logic [31:0]          rb_data,
  input  mem_fifo_pkg::word_t  forced_bit_err
);

  import mem_fifo_pkg::*;

  // Streams between blocks
  word_t gen_tdata, chk_tdata, fin_tdata, fout_tdata;
  logic  gen_tlast, gen_tvalid, gen_tready;
  logic  chk_tlast, chk_tvalid;
  logic  fin_tlast, fin_tvalid, fin_tready;
  logic  fout_tlast, fout_tvalid, fout_tready;

  // Memory side
  logic [ADDR_W:0]   wr_ptr, rd_ptr, occupancy;
  logic              wr_req, wr_gnt, rd_req, rd_gnt;
  logic [ADDR_W-1:0] wr_addr, rd_addr;
  logic [64:0]       wr_data, rd_data;

  // Control levels
  logic        bist_mode, bist_go, bist_cont, bist_ramp, fifo_clr;
  logic [12:0] pkt_len;
  logic [17:0] pkt_count;
  logic [31:0] seed;
  logic        running, done;
  bist_err_e   error;

  stream_router stream_router_inst (
    .bus_clk, .rst, .bist_mode,
    .usr_tdata(i_tdata), .usr_tlast(i_tlast), .usr_tvalid(i_tvalid), .usr_tready(i_tready),
    .gen_tdata, .gen_tlast, .gen_tvalid, .gen_tready,
    .fifo_in_tdata(fin_tdata), .fifo_in_tlast(fin_tlast),
    .fifo_in_tvalid(fin_tvalid), .fifo_in_tready(fin_tready),
    .fifo_out_tdata(fout_tdata), .fifo_out_tlast(fout_tlast),
    .fifo_out_tvalid(fout_tvalid), .fifo_out_tready(fout_tready),
    .o_tdata, .o_tlast, .o_tvalid, .o_tready,
    .chk_tdata, .chk_tlast, .chk_tvalid, .forced_bit_err
  );

  fifo_write_engine #(.ADDR_W(ADDR_W)) fifo_write_engine_inst (
    .bus_clk, .rst, .clr(fifo_clr),
    .in_tdata(fin_tdata), .in_tlast(fin_tlast), .in_tvalid(fin_tvalid), .in_tready(fin_tready),
    .rd_ptr, .wr_ptr, .wr_req, .wr_gnt, .wr_addr, .wr_data
  );

  fifo_read_engine #(.ADDR_W(ADDR_W)) fifo_read_engine_inst (
    .bus_clk, .rst, .clr(fifo_clr), .wr_ptr, .rd_ptr, .rd_req, .rd_gnt, .rd_addr, .rd_data,
    .out_tdata(fout_tdata), .out_tlast(fout_tlast),
    .out_tvalid(fout_tvalid), .out_tready(fout_tready), .occupancy
  );

  mem_port_arbiter #(.ADDR_W(ADDR_W)) mem_port_arbiter_inst (
    .bus_clk, .rst, .wr_req, .wr_gnt, .wr_addr, .wr_data, .rd_req, .rd_gnt, .rd_addr, .rd_data
  );

  bist_engine bist_engine_inst (
    .bus_clk, .rst, .go(bist_go), .cont(bist_cont), .ramp(bist_ramp),
    .pkt_len, .pkt_count, .seed,
    .gen_tdata, .gen_tlast, .gen_tvalid, .gen_tready,
    .chk_tdata, .chk_tlast, .chk_tvalid, .running, .done, .error
  );

  ctrl_regs #(
    .ADDR_W(ADDR_W),
    .SR_FIFO_BASE(SR_FIFO_BASE),
    .SR_BIST_BASE(SR_BIST_BASE)
  ) ctrl_regs_inst (
    .bus_clk, .rst, .set_stb, .set_addr, .set_data, .rb_data,
    .bist_mode, .bist_go, .bist_cont, .bist_ramp, .pkt_len, .pkt_count, .seed, .fifo_clr,
    .running, .done, .error, .occupancy,
    .xfer_beat(o_tvalid & o_tready),
    .fifo_busy((occupancy != '0) | fout_tvalid)
  );

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
//----------------------------------------
// Testbench clock and reset generator
//----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic bus_clk,
  output logic rst
);

  initial
  begin
    bus_clk = 1'b0;
    forever #(PERIOD / 2) bus_clk = ~bus_clk;
  end

  // Reset is released on a falling edge away from the sampling edge
  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    @(negedge bus_clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* verif/mem_fifo_tb.sv */
//----------------------------------------
// Memory FIFO testbench
// Directed tests for user path, BIST, counters and back-pressure
//----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_fifo_tb;

  import mem_fifo_pkg::*;

  localparam int ADDR_W       = 8;
  localparam int MEM_DEPTH    = 2 ** ADDR_W;
  localparam int SR_FIFO_BASE = 0;
  localparam int SR_BIST_BASE = 4;
  localparam int MAX_CYCLES   = 60000;
  localparam int DONE_LIMIT   = 20000;

  localparam logic [7:0] FIFO_SEL_ADDR  = 8'(SR_FIFO_BASE + SR_FIFO_SEL);
  localparam logic [7:0] FIFO_CLR_ADDR  = 8'(SR_FIFO_BASE + SR_FIFO_CLR);
  localparam logic [7:0] BIST_CTRL_ADDR = 8'(SR_BIST_BASE + SR_BIST_CTRL);
  localparam logic [7:0] BIST_CFG_ADDR  = 8'(SR_BIST_BASE + SR_BIST_CFG);
  localparam logic [7:0] BIST_SEED_ADDR = 8'(SR_BIST_BASE + SR_BIST_SEED);

  logic        bus_clk;
  logic        rst;
  word_t       i_tdata;
  logic        i_tlast;
  logic        i_tvalid;
  logic        i_tready;
  word_t       o_tdata;
  logic        o_tlast;
  logic        o_tvalid;
  logic        o_tready;
  logic        set_stb;
  logic [7:0]  set_addr;
  logic [31:0] set_data;
  logic [31:0] rb_data;
  word_t       forced_bit_err;

  // Words to send and words expected back as {last, data}
  logic [64:0] tx_q [$];
  logic [64:0] exp_q [$];

  string cur_test;
  int    err_count;
  int    test_err_start;
  int    pass_tests;
  int    fail_tests;
  int    cycle_count;

  tb_clock #(.PERIOD(10), .RESET_CYCLES(4)) tb_clock_inst (.bus_clk, .rst);

  mem_fifo_top #(
    .ADDR_W(ADDR_W),
    .SR_FIFO_BASE(SR_FIFO_BASE),
    .SR_BIST_BASE(SR_BIST_BASE)
  ) mem_fifo_top_inst (
    .bus_clk, .rst,
    .i_tdata, .i_tlast, .i_tvalid, .i_tready,
    .o_tdata, .o_tlast, .o_tvalid, .o_tready,
    .set_stb, .set_addr, .set_data, .rb_data, .forced_bit_err
  );

  //----------------------------------------
  // Bookkeeping
  //----------------------------------------
  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = err_count;
  endtask

  task automatic end_test();
    if (err_count == test_err_start)
    begin
      pass_tests++;
      $display("Test %s: ok", cur_test);
    end
    else
    begin
      fail_tests++;
      $display("Test %s: %0d errors", cur_test, err_count - test_err_start);
    end
  endtask

  task automatic report_mismatch(input string what, input logic [64:0] expected,
                                 input logic [64:0] actual);
    $display("Error %s: %s expected %h actual %h", cur_test, what, expected, actual);
    err_count++;
  endtask

  //----------------------------------------
  // Settings bus
  //----------------------------------------
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge bus_clk);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(negedge bus_clk);
    set_stb  = 1'b0;
  endtask

  // Readback follows the select one cycle after the write
  task automatic read_reg(input rb_sel_e sel, output logic [31:0] value);
    write_reg(FIFO_SEL_ADDR, 32'(sel));
    value = rb_data;
  endtask

  //----------------------------------------
  // Stream driver and monitor
  //----------------------------------------
  task automatic queue_packet(input int len);
    logic [64:0] word;
    for (int i = 0; i < len; i++)
    begin
      word = {(i == len - 1), $urandom, $urandom};
      tx_q.push_back(word);
      exp_q.push_back(word);
    end
  endtask

  // i_tready only moves on rising edges, so it is stable here
  task automatic drive_stream();
    while (tx_q.size() > 0)
    begin
      @(negedge bus_clk);
      i_tvalid = 1'b1;
      {i_tlast, i_tdata} = tx_q[0];
      if (i_tready)
        void'(tx_q.pop_front());
    end
    @(negedge bus_clk);
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
  endtask

  task automatic collect_stream(input int count, input int stall_pct);
    int          got;
    logic [64:0] exp_word;
    got = 0;
    while (got < count)
    begin
      @(negedge bus_clk);
      o_tready = ($urandom_range(99) >= stall_pct);
      if (o_tvalid && o_tready)
      begin
        exp_word = exp_q.pop_front();
        if ({o_tlast, o_tdata} !== exp_word)
          report_mismatch($sformatf("word %0d", got), exp_word, {o_tlast, o_tdata});
        got++;
      end
    end
  endtask

  //----------------------------------------
  // BIST helpers
  //----------------------------------------
  task automatic wait_bist_done(input bist_err_e exp_err);
    logic [31:0] status;
    int          waited;
    read_reg(RB_BIST_STATUS, status);
    waited = 0;
    while (!rb_data[1] && waited < DONE_LIMIT)
    begin
      @(negedge bus_clk);
      waited++;
    end
    status = rb_data;
    if (!status[1])
    begin
      $display("BIST done did not rise within %0d cycles in test %s", DONE_LIMIT, cur_test);
      err_count++;
    end
    else
    begin
      if (status[0] !== 1'b0)
        report_mismatch("running", 65'(1'b0), 65'(status[0]));
      if (status[3:2] !== exp_err)
        report_mismatch("error", 65'(exp_err), 65'(status[3:2]));
    end
  endtask

  task automatic run_bist(input logic [31:0] cfg, input logic [31:0] seed_val,
                          input bist_err_e exp_err);
    write_reg(BIST_SEED_ADDR, seed_val);
    write_reg(BIST_CFG_ADDR, cfg);
    write_reg(BIST_CTRL_ADDR, 32'd0);
    write_reg(BIST_CTRL_ADDR, 32'd1);
    wait_bist_done(exp_err);
    write_reg(BIST_CTRL_ADDR, 32'd0);
  endtask

  //----------------------------------------
  // Directed tests
  //----------------------------------------
  task automatic test_passthrough();
    start_test("passthrough");
    for (int p = 0; p < 3; p++)
      queue_packet(int'($urandom_range(40, 1)));
    fork
      drive_stream();
      collect_stream(exp_q.size(), 30);
    join
    end_test();
  endtask

  task automatic test_bist_finite();
    start_test("bist_finite");
    run_bist((32'd5 << 18) | 32'd10, 32'h1234_5678, BIST_OK);
    end_test();
  endtask

  task automatic test_fault_injection();
    start_test("fault_injection");
    @(negedge bus_clk);
    forced_bit_err = 64'h8000_0000_0000_0000;
    run_bist(32'h8000_0000 | (32'd6 << 18) | 32'd4, 32'h0000_0100, BIST_DATA_ERR);
    @(negedge bus_clk);
    forced_bit_err = '0;
    run_bist(32'h8000_0000 | (32'd6 << 18) | 32'd4, 32'h0000_0100, BIST_OK);
    end_test();
  endtask

  task automatic test_continuous();
    logic [31:0] status;
    start_test("continuous");
    write_reg(BIST_CTRL_ADDR, 32'd0);
    write_reg(BIST_CTRL_ADDR, 32'd3);
    repeat (500) @(negedge bus_clk);
    read_reg(RB_BIST_STATUS, status);
    if (status[0] !== 1'b1)
      report_mismatch("running", 65'(1'b1), 65'(status[0]));
    // Drop go and keep cont
    write_reg(BIST_CTRL_ADDR, 32'd2);
    wait_bist_done(BIST_OK);
    write_reg(BIST_CTRL_ADDR, 32'd0);
    end_test();
  endtask

  task automatic test_clear_counters();
    logic [31:0] value;
    int          n;
    start_test("clear_counters");
    write_reg(FIFO_CLR_ADDR, 32'd1);
    write_reg(FIFO_CLR_ADDR, 32'd0);
    read_reg(RB_XFER_COUNT, value);
    if (value !== 32'd0)
      report_mismatch("xfer count after clear", 65'(0), 65'(value));
    queue_packet(int'($urandom_range(20, 1)));
    queue_packet(int'($urandom_range(20, 1)));
    n = exp_q.size();
    fork
      drive_stream();
      collect_stream(n, 20);
    join
    read_reg(RB_XFER_COUNT, value);
    if (value !== 32'(n))
      report_mismatch("xfer count", 65'(n), 65'(value));
    read_reg(RB_CYCLE_COUNT, value);
    if (value < 32'(n))
    begin
      $display("Error %s: cycle count expected at least %0d actual %0d", cur_test, n, value);
      err_count++;
    end
    end_test();
  endtask

  task automatic test_back_pressure();
    logic [64:0] word;
    logic [31:0] value;
    int          accepted;
    int          low_run;
    start_test("back_pressure");
    accepted = 0;
    low_run  = 0;
    word     = {1'b0, $urandom, $urandom};
    // Fill until i_tready has stayed low for a while
    while (low_run < 16 && accepted < 1000)
    begin
      @(negedge bus_clk);
      o_tready = 1'b0;
      i_tvalid = 1'b1;
      {i_tlast, i_tdata} = word;
      if (i_tready)
      begin
        exp_q.push_back(word);
        accepted++;
        low_run = 0;
        word = {1'b0, $urandom, $urandom};
      end
      else
        low_run++;
    end
    if (low_run < 16)
    begin
      $display("Input ready never dropped in test %s", cur_test);
      err_count++;
    end
    if (accepted < MEM_DEPTH)
    begin
      $display("Error %s: accepted words expected at least %0d actual %0d",
               cur_test, MEM_DEPTH, accepted);
      err_count++;
    end
    // Memory is full while the output is held off
    read_reg(RB_FIFO_STATUS, value);
    if (value !== 32'(MEM_DEPTH))
      report_mismatch("memory occupancy", 65'(MEM_DEPTH), 65'(value));
    // Pending word stays valid, then a last word closes the packet
    tx_q.push_back(word);
    exp_q.push_back(word);
    word = {1'b1, $urandom, $urandom};
    tx_q.push_back(word);
    exp_q.push_back(word);
    fork
      drive_stream();
      collect_stream(exp_q.size(), 0);
    join
    end_test();
  endtask

  //----------------------------------------
  // Run control
  //----------------------------------------
  initial
  begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES)
    begin
      @(posedge bus_clk);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    void'($urandom(32'hc0ee_8449));
    i_tdata        = '0;
    i_tlast        = 1'b0;
    i_tvalid       = 1'b0;
    o_tready       = 1'b0;
    set_stb        = 1'b0;
    set_addr       = '0;
    set_data       = '0;
    forced_bit_err = '0;
    err_count      = 0;
    pass_tests     = 0;
    fail_tests     = 0;
    @(negedge bus_clk);
    while (rst)
      @(negedge bus_clk);

    test_passthrough();
    test_bist_finite();
    test_fault_injection();
    test_continuous();
    test_clear_counters();
    test_back_pressure();

    $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
    if (fail_tests == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* mem_fifo_top.f */
source/mem_fifo_pkg.sv
source/stream_router.sv
source/fifo_write_engine.sv
source/fifo_read_engine.sv
source/mem_port_arbiter.sv
source/bist_engine.sv
source/ctrl_regs.sv
source/mem_fifo_top.sv
verif/tb_clock.sv
verif/mem_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f mem_fifo_top.f --top-module mem_fifo_tb \
  --Mdir obj_dir -o mem_fifo_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/mem_fifo_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -qx "Verification passed" sim.log && exit 0 || exit 1
